//--- hdl/emu_macros.svh
`ifndef EMU_MACROS_SVH
`define EMU_MACROS_SVH

// accumulator and memory data width
`define EMU_ACC_W 32

// memory pointer width
`define EMU_PTR_W 4

// number of target memory entries
`define EMU_DEPTH 16

// flip-flop and memory scan word width
`define EMU_SCAN_W 64

`endif

//--- hdl/emu_pkg.sv
`include "emu_macros.svh"

package emu_pkg;

    // sender phases of the four-phase output channel
    typedef enum logic [1:0] {
        out_idle         = 2'd0,
        out_req_high     = 2'd1,
        out_wait_ack_low = 2'd2
    } out_phase_e;

    // core state, first word of the flip-flop chain
    typedef struct packed {
        logic [`EMU_ACC_W-1:0]                        acc;
        logic [`EMU_PTR_W-1:0]                        ptr;
        logic [`EMU_SCAN_W-`EMU_ACC_W-`EMU_PTR_W-1:0] pad;
    } tgt_state_t;

    // output port state, last word of the flip-flop chain
    typedef struct packed {
        out_phase_e                          phase;
        logic [`EMU_ACC_W-1:0]               sum;
        logic [`EMU_SCAN_W-`EMU_ACC_W-3:0]   pad;
    } out_word_t;

    typedef struct packed {
        logic                  valid;
        logic [`EMU_ACC_W-1:0] sum;
    } emit_t;

endpackage

//--- hdl/emu_ctrl.sv
module emu_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic pause,
    input  logic stall,
    input  logic port_busy,
    input  logic up_req,
    input  logic down_req,
    output logic up,
    output logic down,
    output logic fire
);

    logic run;

    // the up handshake sets the run flag and the down handshake clears it
    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
        end else if (up_req) begin
            run <= 1'b1;
        end else if (down_req) begin
            run <= 1'b0;
        end
    end

    // up acknowledges one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            up <= 1'b0;
        end else begin
            up <= up_req;
        end
    end

    // down waits until the target has stopped and the last sum has left
    always_ff @(posedge clk) begin
        if (rst) begin
            down <= 1'b0;
        end else begin
            down <= down_req && !run && !port_busy;
        end
    end

    // one target cycle per host cycle while running and unblocked
    assign fire = run && !pause && !stall;

    // the host never asks for start and stop at once
    a_no_up_down: assert property (
        @(posedge clk) disable iff (rst)
        !(up_req && down_req)
    );

endmodule

//--- hdl/tgt_core.sv
`include "emu_macros.svh"

module tgt_core
    import emu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fire,
    input  logic                   ff_scan,
    input  logic [`EMU_SCAN_W-1:0] chain_in,
    output logic [`EMU_SCAN_W-1:0] state_word,
    input  logic                   port_busy,
    output logic                   stall,
    output emit_t                  emit,
    output logic [`EMU_PTR_W-1:0]  mem_addr,
    input  logic [`EMU_ACC_W-1:0]  mem_rdata,
    output logic [`EMU_ACC_W-1:0]  mem_wdata
);

    localparam logic [`EMU_PTR_W-1:0] last_ptr = `EMU_PTR_W'(`EMU_DEPTH - 1);

    tgt_state_t            st;
    logic [`EMU_ACC_W-1:0] sum;
    logic                  at_last;

    assign at_last = (st.ptr == last_ptr);

    // memory read is combinational, so the sum is ready in the same cycle
    assign sum = st.acc + mem_rdata;

    assign mem_addr  = st.ptr;
    assign mem_wdata = sum;

    // hold at the last entry while the previous sum is still in flight
    assign stall = at_last && port_busy;

    // a wrap of the pointer hands the new sum to the output port
    assign emit.valid = fire && at_last;
    assign emit.sum   = sum;

    assign state_word = st;

    always_ff @(posedge clk) begin
        if (rst) begin
            st <= '0;
        end else if (ff_scan) begin
            st <= tgt_state_t'(chain_in);
        end else if (fire) begin
            st.acc <= sum;
            st.ptr <= st.ptr + 1'b1;
        end
    end

    // scan only happens while the target is frozen
    a_no_fire_in_scan: assert property (
        @(posedge clk) disable iff (rst)
        !(fire && ff_scan)
    );

endmodule

//--- hdl/tgt_ram.sv
`include "emu_macros.svh"

module tgt_ram (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fire,
    input  logic [`EMU_PTR_W-1:0]  addr,
    input  logic [`EMU_ACC_W-1:0]  wdata,
    output logic [`EMU_ACC_W-1:0]  rdata,
    input  logic                   ram_scan,
    input  logic                   ram_dir,
    input  logic [`EMU_SCAN_W-1:0] ram_sdi,
    output logic [`EMU_SCAN_W-1:0] ram_sdo
);

    logic [`EMU_ACC_W-1:0] mem [`EMU_DEPTH];
    logic [`EMU_PTR_W-1:0] scan_ptr;

    assign rdata = mem[addr];

    // scan output shows the entry before any overwrite in this step
    assign ram_sdo = {{(`EMU_SCAN_W - `EMU_ACC_W){1'b0}}, mem[scan_ptr]};

    always_ff @(posedge clk) begin
        if (fire) begin
            mem[addr] <= wdata;
        end else if (ram_scan && ram_dir) begin
            mem[scan_ptr] <= ram_sdi[`EMU_ACC_W-1:0];
        end
    end

    // wraps after the last entry, ready for the next pass
    always_ff @(posedge clk) begin
        if (rst) begin
            scan_ptr <= '0;
        end else if (ram_scan) begin
            scan_ptr <= scan_ptr + 1'b1;
        end
    end

    // target and scan never share the memory in one cycle
    a_no_fire_in_scan: assert property (
        @(posedge clk) disable iff (rst)
        !(fire && ram_scan)
    );

endmodule

//--- hdl/out_port.sv
`include "emu_macros.svh"

module out_port
    import emu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  emit_t                  emit,
    output logic                   busy,
    input  logic                   ff_scan,
    input  logic [`EMU_SCAN_W-1:0] chain_in,
    output logic [`EMU_SCAN_W-1:0] ff_sdo,
    output logic                   out_req,
    input  logic                   out_ack,
    output logic [`EMU_ACC_W-1:0]  out_data
);

    out_word_t w;

    assign busy     = (w.phase != out_idle);
    assign out_req  = (w.phase == out_req_high);
    assign out_data = w.sum;

    // last link of the chain
    assign ff_sdo = w;

    always_ff @(posedge clk) begin
        if (rst) begin
            w <= '0;
        end else if (ff_scan) begin
            w <= out_word_t'(chain_in);
        end else begin
            case (w.phase)
                out_idle: begin
                    if (emit.valid) begin
                        w.sum   <= emit.sum;
                        w.phase <= out_req_high;
                    end
                end
                out_req_high: begin
                    if (out_ack) begin
                        w.phase <= out_wait_ack_low;
                    end
                end
                out_wait_ack_low: begin
                    if (!out_ack) begin
                        w.phase <= out_idle;
                    end
                end
                // unused code can only come in through the scan chain
                default: w.phase <= out_idle;
            endcase
        end
    end

    // the core stall keeps a new sum away until the last one is acknowledged
    a_emit_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        emit.valid |-> !busy
    );

endmodule

//--- hdl/emu_top.sv
`include "emu_macros.svh"

module emu_top
    import emu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pause,
    input  logic                   ff_scan,
    input  logic                   ff_dir,
    input  logic [`EMU_SCAN_W-1:0] ff_sdi,
    output logic [`EMU_SCAN_W-1:0] ff_sdo,
    input  logic                   ram_scan,
    input  logic                   ram_dir,
    input  logic [`EMU_SCAN_W-1:0] ram_sdi,
    output logic [`EMU_SCAN_W-1:0] ram_sdo,
    input  logic                   up_req,
    input  logic                   down_req,
    output logic                   up,
    output logic                   down,
    output logic                   out_req,
    input  logic                   out_ack,
    output logic [`EMU_ACC_W-1:0]  out_data
);

    logic                   fire;
    logic                   stall;
    logic                   port_busy;
    logic [`EMU_SCAN_W-1:0] chain_in;
    logic [`EMU_SCAN_W-1:0] state_word;
    emit_t                  emit;
    logic [`EMU_PTR_W-1:0]  mem_addr;
    logic [`EMU_ACC_W-1:0]  mem_rdata;
    logic [`EMU_ACC_W-1:0]  mem_wdata;

    // ff_dir low recirculates the chain onto itself
    assign chain_in = ff_dir ? ff_sdi : ff_sdo;

    emu_ctrl ctrl0 (
        .clk       (clk),
        .rst       (rst),
        .pause     (pause),
        .stall     (stall),
        .port_busy (port_busy),
        .up_req    (up_req),
        .down_req  (down_req),
        .up        (up),
        .down      (down),
        .fire      (fire)
    );

    tgt_core core0 (
        .clk        (clk),
        .rst        (rst),
        .fire       (fire),
        .ff_scan    (ff_scan),
        .chain_in   (chain_in),
        .state_word (state_word),
        .port_busy  (port_busy),
        .stall      (stall),
        .emit       (emit),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_wdata  (mem_wdata)
    );

    tgt_ram ram0 (
        .clk      (clk),
        .rst      (rst),
        .fire     (fire),
        .addr     (mem_addr),
        .wdata    (mem_wdata),
        .rdata    (mem_rdata),
        .ram_scan (ram_scan),
        .ram_dir  (ram_dir),
        .ram_sdi  (ram_sdi),
        .ram_sdo  (ram_sdo)
    );

    // second chain word follows the core state word
    out_port port0 (
        .clk      (clk),
        .rst      (rst),
        .emit     (emit),
        .busy     (port_busy),
        .ff_scan  (ff_scan),
        .chain_in (state_word),
        .ff_sdo   (ff_sdo),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data)
    );

endmodule

//--- testbench/emu_checker.sv
`include "emu_macros.svh"

module emu_checker
    import emu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ff_scan,
    input  logic [`EMU_SCAN_W-1:0] ff_sdo,
    input  logic [`EMU_SCAN_W-1:0] ram_sdo,
    input  logic                   up,
    input  logic                   down,
    input  logic                   out_req,
    input  logic [`EMU_ACC_W-1:0]  out_data,
    input  logic                   cmp_en,
    input  logic [1:0]             cmp_sel,
    input  logic [`EMU_SCAN_W-1:0] cmp_exp,
    input  logic [2:0]             cmp_test,
    input  logic                   exp_push,
    input  logic [`EMU_ACC_W-1:0]  exp_sum,
    input  logic [2:0]             exp_test,
    input  logic                   quiet,
    output int                     val_errs,
    output int                     proto_errs,
    output int                     pending
);

    // expected sums in arrival order with the test id above the sum
    logic [`EMU_ACC_W+2:0] exp_q [$];
    logic                  req_q;
    logic [`EMU_ACC_W-1:0] held;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1: return "reset";
            3'd2: return "ram_scan";
            3'd3: return "ff_scan";
            3'd4: return "run_emit";
            3'd5: return "backpressure";
            3'd6: return "down";
            default: return "unknown";
        endcase
    endfunction

    initial begin
        val_errs   = 0;
        proto_errs = 0;
        pending    = 0;
        req_q      = 1'b0;
        held       = '0;
    end

    // sampled mid-cycle where inputs and DUT outputs are settled
    always @(negedge clk) begin
        logic [`EMU_SCAN_W-1:0] got;
        logic [`EMU_ACC_W+2:0]  head;
        if (!rst) begin
            if (exp_push) begin
                exp_q.push_back({exp_test, exp_sum});
            end
            if (cmp_en) begin
                case (cmp_sel)
                    2'd0: got = ff_sdo;
                    2'd1: got = ram_sdo;
                    default: got = {{(`EMU_SCAN_W - 3){1'b0}}, up, down, out_req};
                endcase
                if (got !== cmp_exp) begin
                    $display("[FAIL] %s: expected %h, actual %h",
                             test_name(cmp_test), cmp_exp, got);
                    val_errs++;
                end
            end
            // the chain passes arbitrary words through the port during a shift
            if (!ff_scan && out_req && !req_q) begin
                if (exp_q.size() == 0) begin
                    $display("out_req rose with sum %h but no sum was expected", out_data);
                    proto_errs++;
                end else begin
                    head = exp_q.pop_front();
                    if (out_data !== head[`EMU_ACC_W-1:0]) begin
                        $display("[FAIL] %s: expected %h, actual %h",
                                 test_name(head[`EMU_ACC_W+2:`EMU_ACC_W]),
                                 head[`EMU_ACC_W-1:0], out_data);
                        val_errs++;
                    end
                end
            end
            if (!ff_scan && out_req && req_q && out_data !== held) begin
                $display("out_data changed while out_req was high");
                proto_errs++;
            end
            if (quiet && out_req) begin
                $display("out_req is high after the down handshake completed");
                proto_errs++;
            end
            req_q   = out_req;
            held    = out_data;
            pending = exp_q.size();
        end
    end

endmodule

//--- testbench/emu_tb.sv
`include "emu_macros.svh"

module emu_tb
    import emu_pkg::*;
();

    localparam logic [1:0] cmp_ff   = 2'd0;
    localparam logic [1:0] cmp_ram  = 2'd1;
    localparam logic [1:0] cmp_ctrl = 2'd2;
    localparam logic [1:0] sig_up   = 2'd0;
    localparam logic [1:0] sig_down = 2'd1;
    localparam logic [1:0] sig_req  = 2'd2;
    localparam int wait_limit = 2000;
    localparam int n_run      = 9;
    localparam int n_back     = 12;

    logic clk;
    logic rst;
    logic pause;
    logic ff_scan;
    logic ff_dir;
    logic [`EMU_SCAN_W-1:0] ff_sdi;
    logic [`EMU_SCAN_W-1:0] ff_sdo;
    logic ram_scan;
    logic ram_dir;
    logic [`EMU_SCAN_W-1:0] ram_sdi;
    logic [`EMU_SCAN_W-1:0] ram_sdo;
    logic up_req;
    logic down_req;
    logic up;
    logic down;
    logic out_req;
    logic out_ack;
    logic [`EMU_ACC_W-1:0] out_data;

    logic cmp_en;
    logic [1:0] cmp_sel;
    logic [`EMU_SCAN_W-1:0] cmp_exp;
    logic [2:0] cmp_test;
    logic exp_push;
    logic [`EMU_ACC_W-1:0] exp_sum;
    logic [2:0] exp_test;
    logic quiet;
    int val_errs;
    int proto_errs;
    int pending;

    logic [31:0] lfsr;
    logic [`EMU_ACC_W-1:0] mem_img [`EMU_DEPTH];
    bit pause_en;

    emu_top dut0 (.*);

    emu_checker chk0 (.*);

    always #2 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // n-th sum emitted when the target starts from this memory image and state
    function automatic logic [`EMU_ACC_W-1:0] model_run(input logic [`EMU_ACC_W-1:0] img [`EMU_DEPTH],
                                                        input logic [`EMU_ACC_W-1:0] acc_in,
                                                        input logic [`EMU_PTR_W-1:0] ptr_in,
                                                        input int n);
        logic [`EMU_ACC_W-1:0] m [`EMU_DEPTH];
        logic [`EMU_ACC_W-1:0] acc;
        logic [`EMU_PTR_W-1:0] ptr;
        logic [`EMU_ACC_W-1:0] sum;
        int seen;
        m = img;
        acc = acc_in;
        ptr = ptr_in;
        sum = '0;
        seen = 0;
        for (int s = 0; s < (n + 1) * `EMU_DEPTH; s++) begin
            acc = acc + m[ptr];
            m[ptr] = acc;
            if (ptr == `EMU_PTR_W'(`EMU_DEPTH - 1)) begin
                if (seen == n) begin
                    sum = acc;
                end
                seen++;
            end
            ptr = ptr + 1'b1;
        end
        return sum;
    endfunction

    task automatic end_sim(input logic timed_out);
        $display("errors: value %0d, protocol %0d, missing sums %0d, timeouts %0d",
                 val_errs, proto_errs, pending, timed_out);
        if (!timed_out && val_errs == 0 && proto_errs == 0 && pending == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        cmp_en   <= 1'b0;
        exp_push <= 1'b0;
        if (pause_en) begin
            pause <= (rand_word(2) == 32'd0);
        end
    endtask

    task automatic compare(input logic [1:0] sel, input logic [`EMU_SCAN_W-1:0] value,
                           input logic [2:0] test);
        cmp_en   <= 1'b1;
        cmp_sel  <= sel;
        cmp_exp  <= value;
        cmp_test <= test;
    endtask

    task automatic wait_for(input logic [1:0] sel, input logic level, input string what);
        int t;
        logic seen;
        t = 0;
        seen = 1'b0;
        while (!seen && t < wait_limit) begin
            @(negedge clk);
            case (sel)
                sig_up:   seen = (up == level);
                sig_down: seen = (down == level);
                default:  seen = (out_req == level);
            endcase
            if (!seen) begin
                next_cycle();
                t++;
            end
        end
        if (!seen) begin
            $display("timeout after %0d cycles waiting for %s", wait_limit, what);
            end_sim(1'b1);
        end
    endtask

    // out_port word goes in first and ends up in the last link
    task automatic ff_load(input logic [`EMU_SCAN_W-1:0] first,
                           input logic [`EMU_SCAN_W-1:0] second);
        next_cycle();
        ff_scan <= 1'b1;
        ff_dir  <= 1'b1;
        ff_sdi  <= first;
        next_cycle();
        ff_sdi  <= second;
        next_cycle();
        ff_scan <= 1'b0;
        ff_dir  <= 1'b0;
    endtask

    task automatic ff_recirc(input logic [`EMU_SCAN_W-1:0] after_one,
                             input logic [`EMU_SCAN_W-1:0] after_two, input logic [2:0] test);
        next_cycle();
        ff_scan <= 1'b1;
        ff_dir  <= 1'b0;
        next_cycle();
        compare(cmp_ff, after_one, test);
        next_cycle();
        compare(cmp_ff, after_two, test);
        ff_scan <= 1'b0;
    endtask

    // upper half of each scan word is random and must be dropped
    task automatic ram_load();
        for (int i = 0; i < `EMU_DEPTH; i++) begin
            next_cycle();
            ram_scan <= 1'b1;
            ram_dir  <= 1'b1;
            ram_sdi  <= {rand_word(32), mem_img[i]};
        end
        next_cycle();
        ram_scan <= 1'b0;
        ram_dir  <= 1'b0;
    endtask

    task automatic ram_check(input logic [2:0] test);
        for (int i = 0; i < `EMU_DEPTH; i++) begin
            next_cycle();
            ram_scan <= 1'b1;
            ram_dir  <= 1'b0;
            compare(cmp_ram, {{(`EMU_SCAN_W - `EMU_ACC_W){1'b0}}, mem_img[i]}, test);
        end
        next_cycle();
        ram_scan <= 1'b0;
    endtask

    initial begin
        tgt_state_t st;
        out_word_t ow;
        logic [`EMU_SCAN_W-1:0] core_w;
        logic [`EMU_ACC_W-1:0] acc0;
        int d;
        lfsr = 32'h332c;
        pause_en = 1'b0;
        clk = 1'b0;
        rst = 1'b1;
        pause = 1'b0;
        ff_scan = 1'b0;
        ff_dir = 1'b0;
        ff_sdi = '0;
        ram_scan = 1'b0;
        ram_dir = 1'b0;
        ram_sdi = '0;
        up_req = 1'b0;
        down_req = 1'b0;
        out_ack = 1'b0;
        cmp_en = 1'b0;
        cmp_sel = '0;
        cmp_exp = '0;
        cmp_test = '0;
        exp_push = 1'b0;
        exp_sum = '0;
        exp_test = '0;
        quiet = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        next_cycle();
        compare(cmp_ctrl, '0, 3'd1);
        ff_recirc('0, '0, 3'd1);

        for (int i = 0; i < `EMU_DEPTH; i++) begin
            mem_img[i] = rand_word(32);
        end
        ram_load();
        ram_check(3'd2);

        core_w = {rand_word(32), rand_word(32)};
        ow.phase = out_idle;
        ow.sum = rand_word(32);
        ow.pad = 30'(rand_word(30));
        ff_load(ow, core_w);
        compare(cmp_ff, ow, 3'd3);
        ff_recirc(core_w, ow, 3'd3);

        // run from the last entry so the first fire emits
        for (int i = 0; i < `EMU_DEPTH; i++) begin
            mem_img[i] = rand_word(32);
        end
        ram_load();
        acc0 = rand_word(32);
        st.acc = acc0;
        st.ptr = `EMU_PTR_W'(`EMU_DEPTH - 1);
        st.pad = '0;
        ow = '0;
        ff_load(ow, st);
        for (int k = 0; k < n_run + n_back; k++) begin
            next_cycle();
            exp_push <= 1'b1;
            exp_test <= (k < n_run) ? 3'd4 : 3'd5;
            if (k == 0) begin
                exp_sum <= acc0 + mem_img[`EMU_DEPTH - 1];
            end else begin
                exp_sum <= model_run(mem_img, acc0, st.ptr, k);
            end
        end
        next_cycle();
        up_req <= 1'b1;
        wait_for(sig_up, 1'b1, "up to rise");
        next_cycle();
        up_req <= 1'b0;
        wait_for(sig_up, 1'b0, "up to fall");

        // host side of the output channel, stopping the target on the last sum
        for (int k = 0; k < n_run + n_back; k++) begin
            pause_en = (k >= n_run);
            wait_for(sig_req, 1'b1, "out_req to rise");
            next_cycle();
            if (k == n_run + n_back - 1) begin
                down_req <= 1'b1;
            end
            d = (k >= n_run) ? int'(rand_word(3)) : 0;
            repeat (d) next_cycle();
            out_ack <= 1'b1;
            wait_for(sig_req, 1'b0, "out_req to fall");
            next_cycle();
            out_ack <= 1'b0;
        end
        pause_en = 1'b0;
        pause <= 1'b0;

        wait_for(sig_down, 1'b1, "down to rise");
        next_cycle();
        down_req <= 1'b0;
        wait_for(sig_down, 1'b0, "down to fall");
        next_cycle();
        quiet <= 1'b1;
        repeat (64) next_cycle();
        quiet <= 1'b0;
        next_cycle();
        end_sim(1'b0);
    end

endmodule

//--- build.f
+incdir+hdl
hdl/emu_pkg.sv
hdl/emu_ctrl.sv
hdl/tgt_core.sv
hdl/tgt_ram.sv
hdl/out_port.sv
hdl/emu_top.sv
testbench/emu_checker.sv
testbench/emu_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the harness testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module emu_tb \
    -f build.f \
    -o emu_sim \
    && ./obj_dir/emu_sim | tee /dev/stderr | grep -x "sim passed" > /dev/null \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }

exit 0
